/* program.hex */
// Instruction words from resetPc, one per line, with byte address and mnemonic
3c011234 // 00 lui  r1, 0x1234
34215678 // 04 ori  r1, r1, 0x5678
00211021 // 08 addu r2, r1, r1
00411823 // 0c subu r3, r2, r1
ac030040 // 10 sw   r3, 0x40(r0)
ac020044 // 14 sw   r2, 0x44(r0)
8c040000 // 18 lw   r4, 0(r0)
00812821 // 1c addu r5, r4, r1
ac050048 // 20 sw   r5, 0x48(r0)
8c060004 // 24 lw   r6, 4(r0)
ac06004c // 28 sw   r6, 0x4c(r0)
34070005 // 2c ori  r7, r0, 5
34080005 // 30 ori  r8, r0, 5
10e80002 // 34 beq  r7, r8, 0x40
ac070050 // 38 sw   r7, 0x50(r0)
ac000054 // 3c sw   r0, 0x54(r0)
8c090008 // 40 lw   r9, 8(r0)
11270002 // 44 beq  r9, r7, 0x50
ac090058 // 48 sw   r9, 0x58(r0)
ac08005c // 4c sw   r8, 0x5c(r0)
08000017 // 50 j    0x5c
01285023 // 54 subu r10, r9, r8
ac000060 // 58 sw   r0, 0x60(r0)
ac0a0064 // 5c sw   r10, 0x64(r0)
08000018 // 60 j    0x60
00000000 // 64 nop

/* verilog.f */
cpuPkg.sv
stageHazardIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
bypassController.sv
stallUnit.sv
cpu.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run the testbench from the project root
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f verilog.f -o simv &&
	./obj_dir/simv > sim.log 2>&1 ||
	{ cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
	localparam int expCount = 8;
	localparam int timeoutCycles = 400; // Whole run takes about 45 cycles with reset
	localparam logic [31:0] preload [4] = '{
		32'h0000_1234, 32'h00ab_0000, 32'h7000_0001, 32'hffff_fff0
	};

	logic clk;
	logic rstN;
	logic [31:0] prRd;
	logic [31:2] prAddr;
	logic [31:0] prWd;
	logic prWe;
	logic [31:0] curAddr;

	logic [31:0] dataMem [64];
	logic [31:0] expAddr [expCount]; // Byte address of each store, in program order
	logic [31:0] expData [expCount];
	int expTest [expCount];
	int testErrors [1:6];
	string testName [1:6];
	int storeCount = 0;
	int extraStores = 0;
	int cycleCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	cpu dut0 (
		.clk(clk),
		.rstN(rstN),
		.PrRD(prRd),
		.PrAddr(prAddr),
		.PrWD(prWd),
		.PrWE(prWe),
		.CurAddr(curAddr)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Data memory model

	assign prRd = dataMem[prAddr[7:2]]; // Answers within the same cycle

	always @(posedge clk) begin
		if (prWe === 1'b1) begin
			dataMem[prAddr[7:2]] <= prWd;
		end
	end

	task automatic fillMemory();
		for (int i = 0; i < 64; i++) begin
			dataMem[i] <= {16'hd5a5, 10'h000, 6'(i)};
		end
		for (int i = 0; i < 4; i++) begin
			dataMem[i] <= preload[i];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected stores and reporting

	task automatic expectStore(input int idx, input int n, input logic [31:0] addr,
		input logic [31:0] data);
		expAddr[idx] = addr;
		expData[idx] = data;
		expTest[idx] = n;
	endtask

	task automatic buildExpected();
		logic [31:0] r1, r2, r3, r5, r6, r7, r8, r9, r10;
		r1 = 32'h1234_0000 | 32'h0000_5678; // lui, then ori into the same register
		r2 = r1 + r1;
		r3 = r2 - r1;
		r5 = preload[0] + r1;               // Load-use pair
		r6 = preload[1];
		r7 = 32'd5;
		r8 = 32'd5;
		r9 = preload[2];
		r10 = r9 - r8;                      // Delay slot of the j
		expectStore(0, 2, 32'h40, r3);
		expectStore(1, 2, 32'h44, r2);
		expectStore(2, 3, 32'h48, r5);
		expectStore(3, 4, 32'h4c, r6);
		expectStore(4, 5, 32'h50, r7);  // Delay slot of the taken beq
		expectStore(5, 5, 32'h58, r9);  // Delay slot of the untaken beq
		expectStore(6, 5, 32'h5c, r8);  // Fall-through path
		expectStore(7, 5, 32'h64, r10); // Jump target, store at 0x58 skipped
		testName[1] = "reset and pipeline fill";
		testName[2] = "dependent ALU chain";
		testName[3] = "load-use stall";
		testName[4] = "store data from writeback";
		testName[5] = "branches and jump";
		testName[6] = "store count";
	endtask

	task automatic valueMismatch(input int n, input string msg);
		$display("FAIL %0t: %s", $time, msg);
		testErrors[n]++;
	endtask

	task automatic checkFailed(input int n, input string msg);
		$display("test %0d went wrong: %s", n, msg);
		testErrors[n]++;
	endtask

	task automatic finishTest(input int n);
		if (testErrors[n] == 0) begin
			$display("test %0d, %s: ok", n, testName[n]);
			testsPassed++;
		end else begin
			$display("test %0d, %s: %0d check(s) failed", n, testName[n], testErrors[n]);
			testsFailed++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checkers

	always @(negedge clk) begin
		if (!rstN) begin
			assert (prWe === 1'b0) else checkFailed(1, "bus write during reset");
		end
	end

	// Every bus write is compared with the next entry of the list
	always @(negedge clk) begin
		if (rstN && prWe === 1'b1) begin
			if (storeCount >= expCount) begin
				extraStores++;
				checkFailed(6, $sformatf("extra store to %h after the last expected one",
					{prAddr, 2'b00}));
			end else begin
				assert ({prAddr, 2'b00} === expAddr[storeCount] &&
					prWd === expData[storeCount])
				else valueMismatch(expTest[storeCount],
					$sformatf("store %0d wrote %h to %h, expected %h to %h", storeCount,
					prWd, {prAddr, 2'b00}, expData[storeCount], expAddr[storeCount]));
				if (storeCount == expCount - 1 ||
					expTest[storeCount + 1] != expTest[storeCount]) begin
					finishTest(expTest[storeCount]);
				end
				storeCount++;
			end
		end
	end

	task automatic pipelineFill();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			assert (prWe === 1'b0) else checkFailed(1, "bus write while the pipeline fills");
		end
		// Third edge after reset puts the first word in memory stage
		assert (curAddr === cpuPkg::resetPc)
			else valueMismatch(1, $sformatf("CurAddr %h, expected %h", curAddr,
			cpuPkg::resetPc));
		@(negedge clk);
		assert (curAddr === cpuPkg::resetPc + 32'd4)
			else valueMismatch(1, $sformatf("CurAddr %h, expected %h", curAddr,
			cpuPkg::resetPc + 32'd4));
		finishTest(1);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles) begin
			$display("program did not finish within %0d cycles", timeoutCycles);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int totalErrors;
		totalErrors = 0;
		clk = 1'b0;
		rstN = 1'b0;
		for (int i = 1; i <= 6; i++) begin
			testErrors[i] = 0;
		end
		fillMemory();
		buildExpected();
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		pipelineFill();
		wait (storeCount == expCount);
		repeat (8) @(posedge clk); // Room for a stray store after the list
		assert (extraStores == 0 && storeCount == expCount)
			else checkFailed(6, $sformatf("%0d stores seen, %0d expected",
			storeCount + extraStores, expCount));
		finishTest(6);
		for (int i = 1; i <= 6; i++) begin
			totalErrors += testErrors[i];
		end
		$display("%0d tests passed, %0d failed, %0d failed checks, %0d stores checked",
			testsPassed, testsFailed, totalErrors, storeCount);
		if (totalErrors == 0 && testsFailed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* cpu.sv */
`timescale 1ns/1ps

module cpu (
	input  logic clk,
	input  logic rstN,
	input  logic [31:0] PrRD,
	output logic [31:2] PrAddr,
	output logic [31:0] PrWD,
	output logic PrWE,
	output logic [31:0] CurAddr
);
	cpuPkg::instrWord instr;
	logic stall, redirect, isLoad, isStore, isLoadMem, isStoreMem, storeFwd;
	logic [31:0] target, pcDec, pcEx, pcMem;
	logic [31:0] operand0, operand1, imm32, storeData;
	logic [31:0] exMemResult, storeDataMem, wbData;
	logic [4:0] rAddr0, rAddr1, rAddr0Ex, rAddr1Ex, wAddrEx;
	logic [4:0] rAddr1Mem, wAddrMem, wbAddr;
	logic [cpuPkg::tagWidth-1:0] tUse0, tUse1, tNewEx, tNewMem;
	logic [1:0] aluOp, decFwd0, decFwd1, aluFwd0, aluFwd1;

	stageHazardIf exHz ();
	stageHazardIf memHz ();

	////////////////////////////////////////////////////////////////////////////
	// Pipeline stages

	fetchStage fetch0 (.*);
	decodeStage decode0 (.*);
	executeStage execute0 (.*);
	memStage mem0 (.*);

	////////////////////////////////////////////////////////////////////////////
	// Hazard handling

	bypassController bypass0 (
		.exAddr0(exHz.rAddr0),
		.exAddr1(exHz.rAddr1),
		.memAddr1(memHz.rAddr1),
		.*
	);

	stallUnit stall0 (.*);

endmodule

/* stallUnit.sv */
`timescale 1ns/1ps

module stallUnit (
	input  logic [4:0] rAddr0,
	input  logic [4:0] rAddr1,
	input  logic [cpuPkg::tagWidth-1:0] tUse0,
	input  logic [cpuPkg::tagWidth-1:0] tUse1,
	stageHazardIf.hazard exHz,
	stageHazardIf.hazard memHz,
	output logic stall
);

	// Value arrives after the reader needs it
	function automatic logic late(input logic [4:0] reader,
		input logic [cpuPkg::tagWidth-1:0] tUse);
		late = (reader != '0) &&
			((reader == exHz.wAddr && exHz.tNew > tUse) ||
			(reader == memHz.wAddr && memHz.tNew > tUse));
	endfunction

	always_comb begin
		stall = late(rAddr0, tUse0) || late(rAddr1, tUse1);
	end

endmodule

/* bypassController.sv */
`timescale 1ns/1ps

module bypassController (
	input  logic [4:0] rAddr0,
	input  logic [4:0] rAddr1,
	stageHazardIf.hazard exHz,
	stageHazardIf.hazard memHz,
	input  logic [4:0] exAddr0,
	input  logic [4:0] exAddr1,
	input  logic [4:0] memAddr1,
	input  logic [4:0] wbAddr,
	output logic [1:0] decFwd0,
	output logic [1:0] decFwd1,
	output logic [1:0] aluFwd0,
	output logic [1:0] aluFwd1,
	output logic storeFwd
);

	function automatic logic match(input logic [4:0] reader, input logic [4:0] writer);
		match = (reader != '0) && (reader == writer);
	endfunction

	// Nearest writer wins even when not ready and a later stage fixes it up
	function automatic logic [1:0] decSel(input logic [4:0] reader);
		if (match(reader, exHz.wAddr)) decSel = cpuPkg::fwdReg;
		else if (match(reader, memHz.wAddr) && memHz.tNew == '0) decSel = cpuPkg::fwdExMem;
		else decSel = cpuPkg::fwdReg;
	endfunction

	function automatic logic [1:0] aluSel(input logic [4:0] reader);
		if (match(reader, memHz.wAddr))
			aluSel = (memHz.tNew == '0) ? cpuPkg::fwdExMem : cpuPkg::fwdReg;
		else if (match(reader, wbAddr)) aluSel = cpuPkg::fwdWb;
		else aluSel = cpuPkg::fwdReg;
	endfunction

	always_comb begin
		decFwd0 = decSel(rAddr0);
		decFwd1 = decSel(rAddr1);
		aluFwd0 = aluSel(exAddr0);
		aluFwd1 = aluSel(exAddr1);
	end

	assign storeFwd = match(memAddr1, wbAddr); // Writeback is always ready

endmodule

/* memStage.sv */
`timescale 1ns/1ps

module memStage (
	input  logic clk,
	input  logic rstN,
	input  logic [31:0] exMemResult,
	input  logic [31:0] storeDataMem,
	input  logic [4:0] rAddr1Mem,
	input  logic [4:0] wAddrMem,
	input  logic [cpuPkg::tagWidth-1:0] tNewMem,
	input  logic isLoadMem,
	input  logic isStoreMem,
	input  logic [31:0] pcMem,
	input  logic storeFwd,
	input  logic [31:0] PrRD,
	stageHazardIf.stage memHz,
	output logic [31:2] PrAddr,
	output logic [31:0] PrWD,
	output logic PrWE,
	output logic [31:0] CurAddr,
	output logic [4:0] wbAddr,
	output logic [31:0] wbData
);

	////////////////////////////////////////////////////////////////////////////
	// External bus

	assign PrAddr = exMemResult[31:2];
	assign PrWD = storeFwd ? wbData : storeDataMem; // Load just ahead of the store
	assign PrWE = isStoreMem;
	assign CurAddr = pcMem;

	assign memHz.rAddr0 = '0; // Base already consumed in execute
	assign memHz.rAddr1 = rAddr1Mem;
	assign memHz.wAddr = wAddrMem;
	assign memHz.tNew = tNewMem;

	// Memory/writeback register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAddr <= '0;
		end else begin
			wbAddr <= wAddrMem;
		end
	end

	always_ff @(posedge clk) begin
		wbData <= isLoadMem ? PrRD : exMemResult;
	end

	// Stores carry no destination from decode
	assert property (@(posedge clk) disable iff (!rstN)
		PrWE |-> (wAddrMem == '0 && tNewMem == '0))
		else $error("bus write from a non-store");

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic clk,
	input  logic rstN,
	input  logic [1:0] aluOp,
	input  logic [31:0] operand0,
	input  logic [31:0] operand1,
	input  logic [31:0] imm32,
	input  logic [31:0] storeData,
	input  logic [4:0] rAddr0Ex,
	input  logic [4:0] rAddr1Ex,
	input  logic [4:0] wAddrEx,
	input  logic [cpuPkg::tagWidth-1:0] tNewEx,
	input  logic isLoad,
	input  logic isStore,
	input  logic [31:0] pcEx,
	input  logic [1:0] aluFwd0,
	input  logic [1:0] aluFwd1,
	input  logic [31:0] wbData,
	stageHazardIf.stage exHz,
	output logic [31:0] exMemResult,
	output logic [31:0] storeDataMem,
	output logic [4:0] rAddr1Mem,
	output logic [4:0] wAddrMem,
	output logic [cpuPkg::tagWidth-1:0] tNewMem,
	output logic isLoadMem,
	output logic isStoreMem,
	output logic [31:0] pcMem
);
	logic [31:0] aluA, aluB, storeVal, aluOut, result;

	function automatic logic [31:0] pick(input logic [1:0] sel, input logic [31:0] regVal);
		case (sel)
			cpuPkg::fwdExMem: pick = exMemResult;
			cpuPkg::fwdWb:    pick = wbData;
			default:          pick = regVal;
		endcase
	endfunction

	always_comb begin
		aluA = pick(aluFwd0, operand0);
		aluB = pick(aluFwd1, operand1);
		storeVal = pick(aluFwd1, storeData); // Same rt source as aluB
	end

	always_comb begin
		case (aluOp)
			cpuPkg::aluSub: aluOut = aluA - aluB;
			cpuPkg::aluOr:  aluOut = aluA | aluB;
			cpuPkg::aluLui: aluOut = aluB;
			default:        aluOut = aluA + aluB;
		endcase
	end

	assign result = (isLoad || isStore) ? aluA + imm32 : aluOut; // Effective address

	assign exHz.rAddr0 = rAddr0Ex;
	assign exHz.rAddr1 = rAddr1Ex;
	assign exHz.wAddr = wAddrEx;
	assign exHz.tNew = tNewEx;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rAddr1Mem <= '0;
			wAddrMem <= '0;
			tNewMem <= '0;
			isLoadMem <= 1'b0;
			isStoreMem <= 1'b0;
		end else begin
			rAddr1Mem <= rAddr1Ex;
			wAddrMem <= wAddrEx;
			tNewMem <= (tNewEx == '0) ? '0 : tNewEx - 1'b1; // Saturating countdown
			isLoadMem <= isLoad;
			isStoreMem <= isStore;
		end
	end

	always_ff @(posedge clk) begin
		exMemResult <= result;
		storeDataMem <= storeVal;
		pcMem <= pcEx;
	end

	// A writer must still be counting when it leaves decode
	assert property (@(posedge clk) disable iff (!rstN) (wAddrEx != '0) |-> (tNewEx != '0))
		else $error("zero tNew on a register write");

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  cpuPkg::instrWord instr,
	input  logic [31:0] pcDec,
	input  logic [4:0] wbAddr,
	input  logic [31:0] wbData,
	input  logic [31:0] exMemResult,
	input  logic [1:0] decFwd0,
	input  logic [1:0] decFwd1,
	output logic redirect,
	output logic [31:0] target,
	output logic [4:0] rAddr0,
	output logic [4:0] rAddr1,
	output logic [cpuPkg::tagWidth-1:0] tUse0,
	output logic [cpuPkg::tagWidth-1:0] tUse1,
	output logic [1:0] aluOp,
	output logic [31:0] operand0,
	output logic [31:0] operand1,
	output logic [31:0] imm32,
	output logic [31:0] storeData,
	output logic [4:0] rAddr0Ex,
	output logic [4:0] rAddr1Ex,
	output logic [4:0] wAddrEx,
	output logic [cpuPkg::tagWidth-1:0] tNewEx,
	output logic isLoad,
	output logic isStore,
	output logic [31:0] pcEx
);
	logic [31:0] rf [32];
	logic [31:0] rfRead0, rfRead1, val0, val1;
	logic [31:0] pcPlus4, signImm, bValue;
	logic [5:0] opcode;
	logic [4:0] dAddr;
	logic [1:0] dAluOp;
	logic [cpuPkg::tagWidth-1:0] dTNew;
	logic isArith, dLoad, dStore, isBeq, isJump;

	assign opcode  = instr.rFields.opcode;
	assign isArith = (instr.rFields.funct == cpuPkg::fnAddu) ||
		(instr.rFields.funct == cpuPkg::fnSubu);
	assign signImm = {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};
	assign pcPlus4 = pcDec + 32'd4;

	////////////////////////////////////////////////////////////////////////////
	// Control fields and hazard tags

	always_comb begin
		rAddr0 = '0;
		rAddr1 = '0;
		tUse0 = cpuPkg::tUseNone;
		tUse1 = cpuPkg::tUseNone;
		dAddr = '0;
		dTNew = '0;
		dAluOp = cpuPkg::aluAdd;
		dLoad = 1'b0;
		dStore = 1'b0;
		isBeq = 1'b0;
		isJump = 1'b0;
		case (opcode)
			cpuPkg::opRtype: begin
				if (isArith) begin
					rAddr0 = instr.iFields.rs;
					rAddr1 = instr.iFields.rt;
					tUse0 = cpuPkg::tUseAlu;
					tUse1 = cpuPkg::tUseAlu;
					dAddr = instr.rFields.rd;
					dTNew = cpuPkg::tNewAlu;
					if (instr.rFields.funct == cpuPkg::fnSubu) dAluOp = cpuPkg::aluSub;
				end
			end
			cpuPkg::opOri: begin
				rAddr0 = instr.iFields.rs;
				tUse0 = cpuPkg::tUseAlu;
				dAddr = instr.iFields.rt;
				dTNew = cpuPkg::tNewAlu;
				dAluOp = cpuPkg::aluOr;
			end
			cpuPkg::opLui: begin
				dAddr = instr.iFields.rt;
				dTNew = cpuPkg::tNewAlu;
				dAluOp = cpuPkg::aluLui;
			end
			cpuPkg::opLw: begin
				rAddr0 = instr.iFields.rs; // Address base
				tUse0 = cpuPkg::tUseAlu;
				dAddr = instr.iFields.rt;
				dTNew = cpuPkg::tNewLoad;
				dLoad = 1'b1;
			end
			cpuPkg::opSw: begin
				rAddr0 = instr.iFields.rs;
				rAddr1 = instr.iFields.rt;
				tUse0 = cpuPkg::tUseAlu;
				tUse1 = cpuPkg::tUseStore; // Data needed only in memory
				dStore = 1'b1;
			end
			cpuPkg::opBeq: begin
				rAddr0 = instr.iFields.rs;
				rAddr1 = instr.iFields.rt;
				tUse0 = cpuPkg::tUseBranch;
				tUse1 = cpuPkg::tUseBranch;
				isBeq = 1'b1;
			end
			cpuPkg::opJ: isJump = 1'b1;
			default: ; // Unknown opcodes run as a nop
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Register file with write-through, then decode forwarding

	assign rfRead0 = (rAddr0 == '0) ? '0 : (rAddr0 == wbAddr) ? wbData : rf[rAddr0];
	assign rfRead1 = (rAddr1 == '0) ? '0 : (rAddr1 == wbAddr) ? wbData : rf[rAddr1];
	assign val0 = (decFwd0 == cpuPkg::fwdExMem) ? exMemResult : rfRead0;
	assign val1 = (decFwd1 == cpuPkg::fwdExMem) ? exMemResult : rfRead1;

	always_ff @(posedge clk) begin
		if (wbAddr != '0) begin
			rf[wbAddr] <= wbData;
		end
	end

	// Second ALU input for immediate forms
	assign bValue = (opcode == cpuPkg::opOri) ? {16'h0000, instr.iFields.imm16} :
		(opcode == cpuPkg::opLui) ? {instr.iFields.imm16, 16'h0000} : val1;

	// Both targets are relative to the delay slot
	assign redirect = ((isBeq && (val0 == val1)) || isJump) && !stall;
	assign target = isJump ?
		{pcPlus4[31:28], instr.iFields.rs, instr.iFields.rt, instr.iFields.imm16, 2'b00} :
		pcPlus4 + {signImm[29:0], 2'b00};

	////////////////////////////////////////////////////////////////////////////
	// Decode/execute register

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rAddr0Ex <= '0;
			rAddr1Ex <= '0;
			wAddrEx <= '0;
			tNewEx <= '0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
		end else begin
			rAddr0Ex <= stall ? '0 : rAddr0; // Bubble while stalled
			rAddr1Ex <= stall ? '0 : rAddr1;
			wAddrEx <= stall ? '0 : dAddr;
			tNewEx <= stall ? '0 : dTNew;
			isLoad <= !stall && dLoad;
			isStore <= !stall && dStore;
		end
	end

	always_ff @(posedge clk) begin
		aluOp <= dAluOp;
		operand0 <= val0;
		operand1 <= bValue;
		imm32 <= signImm;
		storeData <= val1;
		pcEx <= pcDec;
	end

	// Forwarding never hands register 0 a value
	assert property (@(posedge clk) disable iff (!rstN)
		(rAddr0 != '0 || val0 == '0) && (rAddr1 != '0 || val1 == '0))
		else $error("register 0 read as non-zero");

endmodule

/* fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic redirect,
	input  logic [31:0] target,
	output cpuPkg::instrWord instr,
	output logic [31:0] pcDec
);
	logic [31:0] rom [cpuPkg::romDepth];
	logic [31:0] pc;

	initial begin
		$readmemh("program.hex", rom);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= cpuPkg::resetPc;
			instr <= '0; // All-zero word decodes as a nop
		end else if (!stall) begin
			pc <= redirect ? target : pc + 32'd4;
			instr <= rom[pc[cpuPkg::romAddrBits+1:2]];
		end
	end

	// PC of the word now in decode
	always_ff @(posedge clk) begin
		if (!stall) begin
			pcDec <= pc;
		end
	end

	// Decode must hold back a branch while it is stalled
	assert property (@(posedge clk) disable iff (!rstN) !(redirect && stall))
		else $error("redirect raised during stall");

endmodule

/* stageHazardIf.sv */
`timescale 1ns/1ps

// One pipeline stage as seen by the hazard logic
interface stageHazardIf;
	logic [4:0] rAddr0; // rs read by the stage
	logic [4:0] rAddr1; // rt read by the stage
	logic [4:0] wAddr;  // Zero when nothing is written
	logic [cpuPkg::tagWidth-1:0] tNew;

	modport stage (
		output rAddr0,
		output rAddr1,
		output wAddr,
		output tNew
	);

	modport hazard (
		input rAddr0,
		input rAddr1,
		input wAddr,
		input tNew
	);
endinterface

/* cpuPkg.sv */
package cpuPkg;

	// Primary opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;

	localparam logic [31:0] resetPc = 32'h0000_0000;
	localparam int romDepth    = 64;
	localparam int romAddrBits = $clog2(romDepth);

	// Hazard timing tags
	localparam int tagWidth = 2;
	localparam logic [tagWidth-1:0] tUseBranch = 2'd0;
	localparam logic [tagWidth-1:0] tUseAlu    = 2'd1;
	localparam logic [tagWidth-1:0] tUseStore  = 2'd2;
	localparam logic [tagWidth-1:0] tUseNone   = 2'd3; // Larger than any tNew
	localparam logic [tagWidth-1:0] tNewAlu    = 2'd1;
	localparam logic [tagWidth-1:0] tNewLoad   = 2'd2;

	localparam logic [1:0] aluAdd = 2'd0;
	localparam logic [1:0] aluSub = 2'd1;
	localparam logic [1:0] aluOr  = 2'd2;
	localparam logic [1:0] aluLui = 2'd3;

	// Forwarding selects
	localparam logic [1:0] fwdReg   = 2'd0;
	localparam logic [1:0] fwdExMem = 2'd1;
	localparam logic [1:0] fwdWb    = 2'd2;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rFields;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;
		} iFields;
	} instrWord;

endpackage
